// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_eeprom -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "All checks passed" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// ==== source/eeprom_i2c_master.sv ====
`timescale 1ns/1ns

module eeprom_i2c_master (
    input  logic                       CLK,
    input  logic                       RESET,
    input  logic                       wr,
    input  logic                       rd,
    input  eeprom_pkg::eeprom_req_t    req,
    output logic                       busy,
    output logic                       ack,
    output eeprom_pkg::eeprom_result_t result,
    output logic                       scl,
    output logic                       sda_low,
    input  logic                       sda_in
);
    import eeprom_pkg::*;

    bit_op_t    bop;
    logic       bop_go;
    logic [7:0] tx_byte;
    logic       master_nak;
    logic       bop_done;
    logic [7:0] rx_byte;
    logic       rx_nak;

    // transaction level
    eeprom_seq_fsm u_seq (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .req        (req),
        .busy       (busy),
        .ack        (ack),
        .result     (result),
        .bop        (bop),
        .bop_go     (bop_go),
        .tx_byte    (tx_byte),
        .master_nak (master_nak),
        .bop_done   (bop_done),
        .rx_byte    (rx_byte),
        .rx_nak     (rx_nak)
    );

    // bus level
    i2c_bit_engine u_engine (
        .CLK        (CLK),
        .RESET      (RESET),
        .bop        (bop),
        .bop_go     (bop_go),
        .tx_byte    (tx_byte),
        .master_nak (master_nak),
        .bop_done   (bop_done),
        .rx_byte    (rx_byte),
        .rx_nak     (rx_nak),
        .scl        (scl),
        .sda_low    (sda_low),
        .sda_in     (sda_in)
    );

endmodule

// ==== source/eeprom_pkg.sv ====
package eeprom_pkg;

    // 2 Kbyte part, upper three bits ride in the control byte
    localparam int ADDR_W = 11;

    localparam logic [3:0] DEV_CODE = 4'b1010; // serial eeprom type code

    // scl low in the first half of a bit, high in the second half
    localparam int PHASES_PER_BIT = 4;

    // sampled with wr or rd
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
    } eeprom_req_t;

    // valid while ack is high
    typedef struct packed {
        logic [7:0] rdata;
        logic       nack;
    } eeprom_result_t;

    typedef enum logic [1:0] {
        BOP_START,
        BOP_STOP,
        BOP_WRITE_BYTE,
        BOP_READ_BYTE
    } bit_op_t;

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA_W,
        S_RESTART, // read only from here
        S_CTRL_R,
        S_DATA_R,
        S_STOP,
        S_DONE
    } seq_state_t;

endpackage

// ==== source/eeprom_seq_fsm.sv ====
`timescale 1ns/1ns

module eeprom_seq_fsm (
    input  logic                       CLK,
    input  logic                       RESET,
    input  logic                       wr,
    input  logic                       rd,
    input  eeprom_pkg::eeprom_req_t    req,
    output logic                       busy,
    output logic                       ack,
    output eeprom_pkg::eeprom_result_t result,
    output eeprom_pkg::bit_op_t        bop,
    output logic                       bop_go,
    output logic [7:0]                 tx_byte,
    output logic                       master_nak,
    input  logic                       bop_done,
    input  logic [7:0]                 rx_byte,
    input  logic                       rx_nak
);
    import eeprom_pkg::*;

    seq_state_t  state;
    eeprom_req_t req_q;
    logic        is_read;
    logic        accept;
    logic        byte_sent;

    // a new strobe is taken in the ack cycle as well
    assign accept = ((state == S_IDLE) || (state == S_DONE)) && (wr || rd);

    assign busy       = (state != S_IDLE) && (state != S_DONE);
    assign ack        = (state == S_DONE);
    assign master_nak = (state == S_DATA_R); // single byte read ends with nak

    assign byte_sent = (state == S_CTRL_W) || (state == S_ADDR) ||
                       (state == S_DATA_W) || (state == S_CTRL_R);

    always_comb
    begin
        case (state)
            S_START, S_RESTART: bop = BOP_START;
            S_STOP:             bop = BOP_STOP;
            S_DATA_R:           bop = BOP_READ_BYTE;
            default:            bop = BOP_WRITE_BYTE;
        endcase
    end

    // control byte is 1010 a10 a9 a8 r/w
    always_comb
    begin
        case (state)
            S_CTRL_W: tx_byte = {DEV_CODE, req_q.addr[ADDR_W-1:8], 1'b0};
            S_CTRL_R: tx_byte = {DEV_CODE, req_q.addr[ADDR_W-1:8], 1'b1};
            S_ADDR:   tx_byte = req_q.addr[7:0];
            S_DATA_W: tx_byte = req_q.wdata;
            default:  tx_byte = 8'h00;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= S_IDLE;
            is_read <= 1'b0;
            bop_go  <= 1'b0;
            result  <= '0;
        end
        else
        begin
            bop_go <= 1'b0;
            if (accept)
            begin
                state   <= S_START;
                is_read <= !wr;      // wr wins
                result  <= '0;
                bop_go  <= 1'b1;
            end
            else if (state == S_DONE)
            begin
                state <= S_IDLE;
            end
            else if (bop_done)
            begin
                bop_go <= 1'b1;
                if (byte_sent && rx_nak)
                begin
                    result.nack <= 1'b1; // sticky until next request
                end
                case (state)
                    S_START:   state <= S_CTRL_W;
                    S_CTRL_W:  state <= rx_nak ? S_STOP : S_ADDR;
                    S_ADDR:
                    begin
                        if (rx_nak)
                        begin
                            state <= S_STOP;
                        end
                        else
                        begin
                            state <= is_read ? S_RESTART : S_DATA_W;
                        end
                    end
                    S_DATA_W:  state <= S_STOP;
                    S_RESTART: state <= S_CTRL_R;
                    S_CTRL_R:  state <= rx_nak ? S_STOP : S_DATA_R;
                    S_DATA_R:
                    begin
                        result.rdata <= rx_byte;
                        state        <= S_STOP;
                    end
                    S_STOP:
                    begin
                        state  <= S_DONE;
                        bop_go <= 1'b0;  // nothing left to issue
                    end
                    default:   state <= S_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            req_q <= req;
        end
    end

endmodule

// ==== source/i2c_bit_engine.sv ====
`timescale 1ns/1ns

module i2c_bit_engine (
    input  logic                CLK,
    input  logic                RESET,
    input  eeprom_pkg::bit_op_t bop,
    input  logic                bop_go,
    input  logic [7:0]          tx_byte,
    input  logic                master_nak,
    output logic                bop_done,
    output logic [7:0]          rx_byte,
    output logic                rx_nak,
    output logic                scl,
    output logic                sda_low,
    input  logic                sda_in
);
    import eeprom_pkg::*;

    localparam int PH_W = $clog2(PHASES_PER_BIT);
    localparam logic [PH_W-1:0] PH_LAST = PH_W'(PHASES_PER_BIT - 1);
    localparam logic [PH_W-1:0] PH_SAMPLE = PH_W'(PHASES_PER_BIT / 2); // first scl high phase
    localparam logic [3:0] ACK_SLOT = 4'd8;

    logic            active;
    bit_op_t         op;
    logic [PH_W-1:0] phase;
    logic [3:0]      bit_cnt;   // 0..7 data, 8 acknowledge
    logic [7:0]      tx_sh;
    logic            nak_bit;
    logic            last_bit;
    logic            phase_wrap;
    logic [PH_W-1:0] next_phase;
    logic [3:0]      next_bit;
    logic [7:0]      next_sh;

    // pull-low level for a given op, bit and phase
    function automatic logic sda_drive(
        input bit_op_t         o,
        input logic [3:0]      b,
        input logic [PH_W-1:0] p,
        input logic            msb,
        input logic            nak
    );
        logic drive;
        case (o)
            BOP_START:      drive = (p == PH_LAST);  // falls with scl high
            BOP_STOP:       drive = (p != PH_LAST);  // rises with scl high
            BOP_WRITE_BYTE: drive = (b < ACK_SLOT) ? ~msb : 1'b0;
            default:        drive = (b < ACK_SLOT) ? 1'b0 : ~nak;
        endcase
        return drive;
    endfunction

    // start and stop are a single bit period
    assign last_bit = (op == BOP_START) || (op == BOP_STOP) || (bit_cnt == ACK_SLOT);

    assign phase_wrap = (phase == PH_LAST);
    assign next_phase = phase_wrap ? '0 : phase + 1'b1;
    assign next_bit   = phase_wrap ? bit_cnt + 4'd1 : bit_cnt;
    assign next_sh    = phase_wrap ? {tx_sh[6:0], 1'b0} : tx_sh;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active   <= 1'b0;
            op       <= BOP_START;
            phase    <= '0;
            bit_cnt  <= '0;
            nak_bit  <= 1'b1;
            bop_done <= 1'b0;
            rx_nak   <= 1'b0;
            scl      <= 1'b1;  // bus idle
            sda_low  <= 1'b0;
        end
        else
        begin
            bop_done <= 1'b0;
            if (!active)
            begin
                if (bop_go)
                begin
                    active  <= 1'b1;
                    op      <= bop;
                    phase   <= '0;
                    bit_cnt <= '0;
                    nak_bit <= master_nak;
                    scl     <= 1'b0;
                    sda_low <= sda_drive(bop, 4'd0, '0, tx_byte[7], master_nak);
                end
            end
            else if (phase_wrap && last_bit)
            begin
                active <= 1'b0; // scl and sda hold until the next op
            end
            else
            begin
                phase   <= next_phase;
                bit_cnt <= next_bit;
                scl     <= (next_phase >= PH_SAMPLE);
                sda_low <= sda_drive(op, next_bit, next_phase, next_sh[7], nak_bit);
                if (phase == PH_SAMPLE && op == BOP_WRITE_BYTE && bit_cnt == ACK_SLOT)
                begin
                    rx_nak <= sda_in;  // high when slave left sda released
                end
                if (next_phase == PH_LAST && last_bit)
                begin
                    bop_done <= 1'b1;
                end
            end
        end
    end

    // data path, no reset needed
    always_ff @(posedge CLK)
    begin
        if (!active && bop_go)
        begin
            tx_sh <= tx_byte;
        end
        else if (active)
        begin
            tx_sh <= next_sh;
        end

        if (active && phase == PH_SAMPLE && op == BOP_READ_BYTE && bit_cnt < ACK_SLOT)
        begin
            rx_byte <= {rx_byte[6:0], sda_in}; // msb first
        end
    end

endmodule

// ==== tb.f ====
source/eeprom_pkg.sv
source/i2c_bit_engine.sv
source/eeprom_seq_fsm.sv
source/eeprom_i2c_master.sv
test/eeprom_slave_model.sv
test/tb_clock_gen.sv
test/eeprom_master_properties.sv
test/tb_eeprom.sv

// ==== test/eeprom_master_properties.sv ====
`timescale 1ns/1ns

module eeprom_master_properties (
    input logic                CLK,
    input logic                RESET,
    input logic                wr,
    input logic                rd,
    input logic                busy,
    input logic                ack,
    input logic                scl,
    input logic                sda_low,
    input logic                active,
    input eeprom_pkg::bit_op_t op,
    input logic [$clog2(eeprom_pkg::PHASES_PER_BIT)-1:0] phase
);
    import eeprom_pkg::*;

    logic seen_strobe;
    logic edge_phase;   // start and stop move sda in their last phase

    always_ff @(posedge CLK)
    begin
        if (RESET)
            seen_strobe <= 1'b0;
        else if (wr || rd)
            seen_strobe <= 1'b1;
    end

    assign edge_phase = active && (phase == 2'(PHASES_PER_BIT - 1)) &&
                        ((op == BOP_START) || (op == BOP_STOP));

    idle_bus: assert property (@(posedge CLK) disable iff (RESET)
        !seen_strobe |-> (scl && !sda_low))
        else $error("bus not idle before first strobe");

    single_ack: assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !ack)
        else $error("ack high for two cycles");

    busy_end: assert property (@(posedge CLK) disable iff (RESET)
        $fell(busy) |-> ack)
        else $error("busy fell without ack");

    sda_steady: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && !edge_phase) |-> $stable(sda_low))
        else $error("sda moved while scl high");

endmodule

bind eeprom_i2c_master eeprom_master_properties u_props (
    .CLK     (CLK),
    .RESET   (RESET),
    .wr      (wr),
    .rd      (rd),
    .busy    (busy),
    .ack     (ack),
    .scl     (scl),
    .sda_low (sda_low),
    .active  (u_engine.active),
    .op      (u_engine.op),
    .phase   (u_engine.phase)
);

// ==== test/eeprom_slave_model.sv ====
`timescale 1ns/1ns

module eeprom_slave_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic nak_block, // refuse every control byte
    output logic pull_low
);
    logic [7:0]  mem [0:2047];
    logic        scl_q;
    logic        sda_q;
    logic        active;
    logic        tx_mode;
    logic        rd_req;
    logic        nak_pend;
    logic        have_data;
    logic [1:0]  stage;     // control, word address, data, beyond
    int          bit_cnt;   // 8 = byte done, 9 = in acknowledge slot
    logic [7:0]  sh;
    logic [7:0]  txb;
    logic [10:0] addr;
    logic [7:0]  wdata;

    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (RESET)
        begin
            for (int i = 0; i < 2048; i++)
                mem[i] <= 8'(i) ^ 8'h5A;
            active    <= 1'b0;
            pull_low  <= 1'b0;
            have_data <= 1'b0;
            addr      <= '0;
        end
        else if (scl_q && scl && sda_q && !sda)
        begin
            active    <= 1'b1; // start or repeated start
            tx_mode   <= 1'b0;
            rd_req    <= 1'b0;
            nak_pend  <= 1'b0;
            stage     <= 2'd0;
            bit_cnt   <= 0;
            have_data <= 1'b0;
        end
        else if (scl_q && scl && !sda_q && sda)
        begin
            if (active && have_data)
                mem[addr] <= wdata; // write cycle on stop
            active    <= 1'b0;
            pull_low  <= 1'b0;
            have_data <= 1'b0;
        end
        else if (active && !scl_q && scl)
        begin
            if (bit_cnt < 8)
            begin
                sh      <= {sh[6:0], sda};
                bit_cnt <= bit_cnt + 1;
            end
            else if (tx_mode && bit_cnt == 8)
            begin
                if (sda)
                    active <= 1'b0; // master nak ends the read
                else
                begin
                    addr    <= addr + 11'd1;
                    bit_cnt <= 9;
                end
            end
        end
        else if (active && scl_q && !scl)
        begin
            if (tx_mode && bit_cnt < 8)
                pull_low <= ~txb[7 - bit_cnt];
            else if (tx_mode && bit_cnt == 8)
                pull_low <= 1'b0;
            else if (bit_cnt == 8)
            begin
                bit_cnt <= 9;
                case (stage)
                    2'd0:
                    begin
                        nak_pend   <= (sh[7:4] != 4'b1010) || nak_block;
                        pull_low   <= (sh[7:4] == 4'b1010) && !nak_block;
                        addr[10:8] <= sh[3:1];
                        rd_req     <= sh[0];
                    end
                    2'd1:
                    begin
                        addr[7:0] <= sh;
                        pull_low  <= 1'b1;
                    end
                    2'd2:
                    begin
                        wdata     <= sh;
                        have_data <= 1'b1;
                        pull_low  <= 1'b1;
                    end
                    default:
                    begin
                        nak_pend <= 1'b1; // no page writes
                        pull_low <= 1'b0;
                    end
                endcase
                if (stage != 2'd3)
                    stage <= stage + 2'd1;
            end
            else if (bit_cnt == 9)
            begin
                bit_cnt <= 0;
                if (nak_pend)
                begin
                    active   <= 1'b0;
                    pull_low <= 1'b0;
                end
                else if (tx_mode || rd_req)
                begin
                    tx_mode  <= 1'b1;
                    txb      <= mem[addr];
                    pull_low <= ~mem[addr][7];
                end
                else
                    pull_low <= 1'b0;
            end
        end
    end

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ns

module tb_clock_gen (
    output logic CLK,
    output logic RESET
);
    initial
    begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    initial
    begin
        RESET = 1'b1;
        repeat (2) @(posedge CLK);
        #1 RESET = 1'b0;
    end

endmodule

// ==== test/tb_eeprom.sv ====
`timescale 1ns/1ns

module tb_eeprom;
    import eeprom_pkg::*;

    typedef struct packed {
        logic        is_read;
        logic [10:0] addr;
        logic [7:0]  wdata;
        logic        nak_block;
        logic        exp_nack;
        logic        extra_strobe; // second strobe while busy
    } row_t;

    logic           CLK;
    logic           RESET;
    logic           wr;
    logic           rd;
    eeprom_req_t    req;
    logic           busy;
    logic           ack;
    eeprom_result_t result;
    logic           scl;
    logic           master_low;
    logic           slave_low;
    logic           sda;
    logic           nak_block;

    row_t        rows[$];
    logic [7:0]  shadow [0:2047];
    logic [31:0] lfsr;
    int          errors;
    int          checks;
    logic        table_ready;

    assign sda = !(master_low || slave_low); // wired and

    tb_clock_gen clk_gen (.CLK(CLK), .RESET(RESET));

    eeprom_i2c_master uut (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .req(req),
        .busy(busy), .ack(ack), .result(result),
        .scl(scl), .sda_low(master_low), .sda_in(sda)
    );

    eeprom_slave_model slave (
        .CLK(CLK), .RESET(RESET), .scl(scl), .sda(sda),
        .nak_block(nak_block), .pull_low(slave_low)
    );

    // fibonacci taps 32 22 2 1
    function automatic logic [31:0] lfsr_take(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic void add_row(input logic is_read, input logic [10:0] a,
                                    input logic [7:0] d, input logic nb,
                                    input logic en, input logic ex);
        row_t r;
        r.is_read      = is_read;
        r.addr         = a;
        r.wdata        = d;
        r.nak_block    = nb;
        r.exp_nack     = en;
        r.extra_strobe = ex;
        rows.push_back(r);
    endfunction

    task automatic build_table();
        logic [10:0] a;
        // same low byte in every block
        for (int b = 0; b < 8; b++)
        begin
            a = {3'(b), 8'h3C};
            add_row(1'b0, a, 8'(lfsr_take(8)), 1'b0, 1'b0, 1'b0);
        end
        for (int b = 0; b < 8; b++)
        begin
            a = {3'(b), 8'h3C};  // read back only after all blocks are written
            add_row(1'b1, a, 8'h00, 1'b0, 1'b0, 1'b0);
        end
        add_row(1'b1, 11'h123, 8'h00, 1'b0, 1'b0, 1'b0);
        add_row(1'b0, 11'h200, 8'hC3, 1'b1, 1'b1, 1'b0);
        add_row(1'b1, 11'h200, 8'h00, 1'b1, 1'b1, 1'b0);
        add_row(1'b1, 11'h200, 8'h00, 1'b0, 1'b0, 1'b0);
        add_row(1'b0, 11'h345, 8'h99, 1'b0, 1'b0, 1'b1);
        add_row(1'b1, 11'h345, 8'h00, 1'b0, 1'b0, 1'b0);
        for (int i = 0; i < 16; i++)
        begin
            a = 11'(lfsr_take(11));
            add_row(lfsr_take(1) == 32'd1, a, 8'(lfsr_take(8)), 1'b0, 1'b0, 1'b0);
        end
    endtask

    task automatic check_result(input eeprom_result_t got, input eeprom_result_t exp,
                                input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED at %0t ns: %s, got rdata %h nack %b, expected rdata %h nack %b",
                     $time, what, got.rdata, got.nack, exp.rdata, exp.nack);
        end
    endtask

    task automatic check_busy(input bit got, input bit exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAILED at %0t ns: %s, busy %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic apply_row(input row_t r, input int idx);
        eeprom_result_t exp;
        int             n;
        @(posedge CLK);
        #1;
        nak_block = r.nak_block;
        req.addr  = r.addr;
        req.wdata = r.wdata;
        wr        = !r.is_read;
        rd        = r.is_read;
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
        check_busy(busy, 1'b1, $sformatf("row %0d busy after strobe", idx));
        if (r.extra_strobe)
        begin
            req.wdata = ~r.wdata;  // must not reach memory
            wr        = 1'b1;
            @(posedge CLK);
            #1;
            wr = 1'b0;
        end
        n = 0;
        while (!ack && n < 400)
        begin
            @(posedge CLK);
            #1;
            n++;
        end
        if (!ack)
        begin
            errors++;
            $display("row %0d got no ack from the DUT within 400 cycles", idx);
        end
        exp.nack  = r.exp_nack;
        exp.rdata = (r.is_read && !r.exp_nack) ? shadow[r.addr] : 8'h00;
        check_result(result, exp, $sformatf("row %0d addr %h", idx, r.addr));
        if (!r.is_read && !r.exp_nack)
            shadow[r.addr] = r.wdata;
        if (r.extra_strobe)
        begin
            repeat (10)
            begin
                @(posedge CLK);
                #1;
                if (ack)
                begin
                    errors++;
                    $display("row %0d saw a second ack after an ignored strobe", idx);
                end
                check_busy(busy, 1'b0, $sformatf("row %0d idle after ack", idx));
            end
        end
    endtask

    initial
    begin
        wr          = 1'b0;
        rd          = 1'b0;
        req         = '0;
        nak_block   = 1'b0;
        errors      = 0;
        checks      = 0;
        table_ready = 1'b0;
        lfsr        = 32'he9ab_dc14;
        for (int i = 0; i < 2048; i++)
            shadow[i] = 8'(i) ^ 8'h5A;
        build_table();
        table_ready = 1'b1;
        @(negedge RESET);
        @(posedge CLK);
        #1;
        check_busy(busy, 1'b0, "busy after reset");
        check_result(result, '0, "result after reset");
        for (int i = 0; i < rows.size(); i++)
            apply_row(rows[i], i);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

    // a read is about 160 cycles, writes are shorter
    initial
    begin
        wait (table_ready);
        #(rows.size() * 150 * 8 + 20000);
        $display("watchdog expired, the DUT stopped finishing its operations");
        $display("Checks failed");
        $finish;
    end

endmodule
